/* logic/dmem_pkg.sv */
package dmem_pkg;

  ////////////////////
  // Widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = 4;   // One strobe per byte lane

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;

  // Access size codes
  typedef logic [1:0] size_t;
  localparam size_t SIZE_BYTE = 2'd0;
  localparam size_t SIZE_HALF = 2'd1;
  localparam size_t SIZE_WORD = 2'd2;

  // AXI constants
  localparam logic [1:0] RESP_OKAY     = 2'b00;
  localparam logic [2:0] AXI_PROT_DATA = 3'b000;  // Unprivileged, secure, data

  ////////////////////
  // Buffered CPU request
  typedef struct packed {
    addr_t addr;
    size_t size;
    logic  we;
    data_t data;   // Already in its byte lanes
  } mem_req_t;

  // One attribute region, limit is inclusive
  typedef struct packed {
    addr_t base;
    addr_t limit;
    logic  readable;
    logic  writable;
  } pma_cfg_t;

  ////////////////////
  // AXI4-Lite channels
  typedef struct packed {
    logic       aw_valid;
    addr_t      aw_addr;
    logic [2:0] aw_prot;
    logic       w_valid;
    data_t      w_data;
    strb_t      w_strb;
    logic       b_ready;
    logic       ar_valid;
    addr_t      ar_addr;
    logic [2:0] ar_prot;
    logic       r_ready;
  } axil_m2s_t;

  typedef struct packed {
    logic       aw_ready;
    logic       w_ready;
    logic       b_valid;
    logic [1:0] b_resp;
    logic       ar_ready;
    logic       r_valid;
    data_t      r_data;
    logic [1:0] r_resp;
  } axil_s2m_t;

endpackage

/* logic/dmem_reqbuf.sv */
`timescale 1ns/1ps

module dmem_reqbuf #(
  parameter int DEPTH = 2
)
(
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               push_i,
  input  dmem_pkg::mem_req_t d_i,
  input  logic               pop_i,
  input  logic               clr_i,
  output logic               ready_o,
  output logic               valid_o,
  output dmem_pkg::mem_req_t q_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  dmem_pkg::mem_req_t mem [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic               do_push;
  logic               do_pop;

  // Wrap at DEPTH, not at a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign ready_o = (count != CNT_W'(DEPTH));  // Low while full
  assign valid_o = (count != '0);
  assign do_push = push_i & ready_o;
  assign do_pop  = pop_i & valid_o;
  assign q_o     = mem[rd_ptr];               // Head entry

  // Entry storage
  always_ff @(posedge clk_i)
  begin
    if (do_push)
      mem[wr_ptr] <= d_i;
  end

  ////////////////////
  // Pointers and fill level
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else if (clr_i)
    begin
      // Drop everything, a push in this cycle is lost too
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= ptr_inc(wr_ptr);
      if (do_pop)
        rd_ptr <= ptr_inc(rd_ptr);
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;     // Idle or push and pop together
      endcase
    end
  end

endmodule

/* logic/dmem_pmachk.sv */
`timescale 1ns/1ps

module dmem_pmachk #(
  parameter int PMA_CNT = 3
)
(
  input  dmem_pkg::mem_req_t req_i,
  input  dmem_pkg::pma_cfg_t pma_cfg_i [PMA_CNT],
  output logic               misaligned_o,
  output logic               pma_err_o
);

  logic [PMA_CNT-1:0] match;    // Address inside region i
  logic               allowed;  // Permission of the lowest matching region

  ////////////////////
  // Misalignment check

  always_comb
  begin
    case (req_i.size)
      dmem_pkg::SIZE_BYTE: misaligned_o = 1'b0;
      dmem_pkg::SIZE_HALF: misaligned_o = req_i.addr[0];
      dmem_pkg::SIZE_WORD: misaligned_o = |req_i.addr[1:0];
      default:             misaligned_o = 1'b1;  // Reserved size code
    endcase
  end

  ////////////////////
  // PMA region lookup

  // Base and limit compare per region
  always_comb
  begin
    for (int i = 0; i < PMA_CNT; i++)
    begin
      match[i] = (req_i.addr >= pma_cfg_i[i].base) &&
                 (req_i.addr <= pma_cfg_i[i].limit);
    end
  end

  // Walk down so the lowest index is written last and wins
  always_comb
  begin
    allowed = 1'b0;  // Stays low when no region matches
    for (int i = PMA_CNT - 1; i >= 0; i--)
    begin
      if (match[i])
        allowed = req_i.we ? pma_cfg_i[i].writable  // Store needs write permission
                           : pma_cfg_i[i].readable; // Load needs read permission
    end
  end

  // Unmapped or forbidden access
  // Misalignment masks it so only one flag is ever reported
  assign pma_err_o = ~misaligned_o & ~allowed;

endmodule

/* logic/dmem_axil_master.sv */
`timescale 1ns/1ps

module dmem_axil_master
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  head_valid_i,
  input  dmem_pkg::mem_req_t    head_i,
  input  logic                  misaligned_i,
  input  logic                  pma_err_i,
  output logic                  pop_o,
  output logic                  flush_o,
  output dmem_pkg::axil_m2s_t   axil_o,
  input  dmem_pkg::axil_s2m_t   axil_i,
  output dmem_pkg::data_t       mem_q_o,
  output logic                  mem_ack_o,
  output logic                  mem_err_o,
  output logic                  mem_misaligned_o
);

  typedef enum logic [2:0] {
    ST_IDLE,     // Wait for a head request
    ST_RESP,     // Response pulse out, head popped
    ST_WR_AW_W,  // Write address and data
    ST_WR_B,     // Write response
    ST_RD_AR,    // Read address
    ST_RD_R      // Read data
  } state_t;

  state_t          state;
  logic            aw_valid;
  logic            w_valid;
  logic            b_ready;
  logic            ar_valid;
  logic            r_ready;
  logic            aw_hs;
  logic            w_hs;
  logic            b_hs;
  logic            ar_hs;
  logic            r_hs;
  logic            aw_w_done;
  logic            b_ok;
  logic            r_ok;
  dmem_pkg::strb_t strb;

  assign aw_hs = aw_valid & axil_i.aw_ready;
  assign w_hs  = w_valid  & axil_i.w_ready;
  assign b_hs  = b_ready  & axil_i.b_valid;
  assign ar_hs = ar_valid & axil_i.ar_ready;
  assign r_hs  = r_ready  & axil_i.r_valid;
  assign b_ok  = (axil_i.b_resp == dmem_pkg::RESP_OKAY);
  assign r_ok  = (axil_i.r_resp == dmem_pkg::RESP_OKAY);

  // Both write channels done, either earlier or in this cycle
  assign aw_w_done = (~aw_valid | axil_i.aw_ready) & (~w_valid | axil_i.w_ready);

  // Byte lanes from size and low address bits
  always_comb
  begin
    case (head_i.size)
      dmem_pkg::SIZE_BYTE: strb = 4'b0001 << head_i.addr[1:0];
      dmem_pkg::SIZE_HALF: strb = 4'b0011 << {head_i.addr[1], 1'b0};
      default:             strb = 4'b1111;
    endcase
  end

  ////////////////////
  // Bus outputs, payload comes straight from the held head
  always_comb
  begin
    axil_o.aw_valid = aw_valid;
    axil_o.aw_addr  = head_i.addr;
    axil_o.aw_prot  = dmem_pkg::AXI_PROT_DATA;
    axil_o.w_valid  = w_valid;
    axil_o.w_data   = head_i.data;
    axil_o.w_strb   = strb;
    axil_o.b_ready  = b_ready;
    axil_o.ar_valid = ar_valid;
    axil_o.ar_addr  = head_i.addr;
    axil_o.ar_prot  = dmem_pkg::AXI_PROT_DATA;
    axil_o.r_ready  = r_ready;
  end

  // Read data capture
  always_ff @(posedge clk_i)
  begin
    if (r_hs)
      mem_q_o <= axil_i.r_data;
  end

  ////////////////////
  // Transfer FSM
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state            <= ST_IDLE;
      aw_valid         <= 1'b0;
      w_valid          <= 1'b0;
      b_ready          <= 1'b0;
      ar_valid         <= 1'b0;
      r_ready          <= 1'b0;
      mem_ack_o        <= 1'b0;
      mem_err_o        <= 1'b0;
      mem_misaligned_o <= 1'b0;
      pop_o            <= 1'b0;
      flush_o          <= 1'b0;
    end
    else
    begin
      // Responses are single-cycle pulses
      mem_ack_o        <= 1'b0;
      mem_err_o        <= 1'b0;
      mem_misaligned_o <= 1'b0;
      pop_o            <= 1'b0;
      flush_o          <= 1'b0;

      case (state)
        ST_IDLE:
        begin
          if (head_valid_i)
          begin
            if (misaligned_i | pma_err_i)
            begin
              // Check failed, no bus activity
              mem_misaligned_o <= misaligned_i;
              mem_err_o        <= pma_err_i;  // Already masked by misalignment
              pop_o            <= 1'b1;
              flush_o          <= 1'b1;
              state            <= ST_RESP;
            end
            else if (head_i.we)
            begin
              aw_valid <= 1'b1;  // AW and W raised together
              w_valid  <= 1'b1;
              state    <= ST_WR_AW_W;
            end
            else
            begin
              ar_valid <= 1'b1;
              state    <= ST_RD_AR;
            end
          end
        end

        ST_WR_AW_W:
        begin
          if (aw_hs)
            aw_valid <= 1'b0;
          if (w_hs)
            w_valid <= 1'b0;
          if (aw_w_done)
          begin
            b_ready <= 1'b1;
            state   <= ST_WR_B;
          end
        end

        ST_WR_B:
        begin
          if (b_hs)
          begin
            b_ready   <= 1'b0;
            mem_ack_o <= b_ok;
            mem_err_o <= ~b_ok;  // SLVERR or DECERR
            pop_o     <= 1'b1;
            flush_o   <= ~b_ok;
            state     <= ST_RESP;
          end
        end

        ST_RD_AR:
        begin
          if (ar_hs)
          begin
            ar_valid <= 1'b0;
            r_ready  <= 1'b1;
            state    <= ST_RD_R;
          end
        end

        ST_RD_R:
        begin
          if (r_hs)
          begin
            r_ready   <= 1'b0;
            mem_ack_o <= r_ok;
            mem_err_o <= ~r_ok;
            pop_o     <= 1'b1;
            flush_o   <= ~r_ok;
            state     <= ST_RESP;
          end
        end

        // Head still visible here, so do not restart it
        ST_RESP: state <= ST_IDLE;

        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

/* logic/dmem_ctrl.sv */
`timescale 1ns/1ps

module dmem_ctrl #(
  parameter int PMA_CNT   = 3,
  parameter int BUF_DEPTH = 2
)
(
  input  logic                clk_i,
  input  logic                rst_n_i,

  // Attribute regions
  input  dmem_pkg::pma_cfg_t  pma_cfg_i [PMA_CNT],

  // CPU side
  input  logic                mem_req_i,
  input  dmem_pkg::mem_req_t  mem_i,
  output logic                mem_ready_o,
  output dmem_pkg::data_t     mem_q_o,
  output logic                mem_ack_o,
  output logic                mem_err_o,
  output logic                mem_misaligned_o,

  // AXI4-Lite master
  output dmem_pkg::axil_m2s_t axil_o,
  input  dmem_pkg::axil_s2m_t axil_i
);

  dmem_pkg::mem_req_t head;        // Oldest pending request
  logic               head_valid;
  logic               misaligned;
  logic               pma_err;
  logic               pop;
  logic               flush;       // Any error empties the buffer

  ////////////////////
  // Request buffer
  dmem_reqbuf #(
    .DEPTH   ( BUF_DEPTH )
  )
  u_reqbuf (
    .clk_i   ( clk_i       ),
    .rst_n_i ( rst_n_i     ),
    .push_i  ( mem_req_i   ),
    .d_i     ( mem_i       ),
    .pop_i   ( pop         ),
    .clr_i   ( flush       ),
    .ready_o ( mem_ready_o ),
    .valid_o ( head_valid  ),
    .q_o     ( head        )
  );

  // Alignment and PMA check on the head
  dmem_pmachk #(
    .PMA_CNT      ( PMA_CNT )
  )
  u_pmachk (
    .req_i        ( head       ),
    .pma_cfg_i    ( pma_cfg_i  ),
    .misaligned_o ( misaligned ),
    .pma_err_o    ( pma_err    )
  );

  ////////////////////
  // Bus access and CPU responses
  dmem_axil_master u_axil_master (
    .clk_i            ( clk_i            ),
    .rst_n_i          ( rst_n_i          ),
    .head_valid_i     ( head_valid       ),
    .head_i           ( head             ),
    .misaligned_i     ( misaligned       ),
    .pma_err_i        ( pma_err          ),
    .pop_o            ( pop              ),
    .flush_o          ( flush            ),
    .axil_o           ( axil_o           ),
    .axil_i           ( axil_i           ),
    .mem_q_o          ( mem_q_o          ),
    .mem_ack_o        ( mem_ack_o        ),
    .mem_err_o        ( mem_err_o        ),
    .mem_misaligned_o ( mem_misaligned_o )
  );

endmodule

/* dv/axil_slave_model.sv */
`timescale 1ns/1ps

module axil_slave_model #(
  parameter int WORDS = 3072       // Covers 0x0000 to 0x2FFF
)
(
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                hold_i,      // Forces all ready outputs low
  input  dmem_pkg::axil_m2s_t axil_i,
  output dmem_pkg::axil_s2m_t axil_o,
  output logic [31:0]         tx_count_o   // Completed transactions
);

  logic [31:0]     mem [WORDS];
  logic [4:0]      rnd;                    // Fresh random bits each cycle
  logic            aw_got;
  logic            w_got;
  logic            ar_got;
  dmem_pkg::addr_t wr_addr;
  dmem_pkg::data_t wr_data;
  dmem_pkg::strb_t wr_strb;
  dmem_pkg::addr_t rd_addr;
  logic            b_valid;
  logic [1:0]      b_resp;
  logic            r_valid;
  dmem_pkg::data_t r_data;
  logic [1:0]      r_resp;

  function automatic logic in_err_window(input dmem_pkg::addr_t addr);
    return (addr >= 32'h0000_2800) && (addr <= 32'h0000_2FFF);
  endfunction

  function automatic int word_index(input dmem_pkg::addr_t addr);
    return int'(addr[13:2]);
  endfunction

  // Fill pattern built from the full word address
  initial
  begin
    for (int i = 0; i < WORDS; i++)
      mem[i] = (32'(i) << 2) ^ 32'hA5A5_0000;
  end

  assign axil_o.aw_ready = ~hold_i & ~aw_got & rnd[0];
  assign axil_o.w_ready  = ~hold_i & ~w_got & rnd[1];
  assign axil_o.ar_ready = ~hold_i & ~ar_got & rnd[2];
  assign axil_o.b_valid  = b_valid;
  assign axil_o.b_resp   = b_resp;
  assign axil_o.r_valid  = r_valid;
  assign axil_o.r_data   = r_data;
  assign axil_o.r_resp   = r_resp;

  always @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      rnd        <= '0;
      aw_got     <= 1'b0;
      w_got      <= 1'b0;
      ar_got     <= 1'b0;
      b_valid    <= 1'b0;
      b_resp     <= 2'b00;
      r_valid    <= 1'b0;
      r_data     <= '0;
      r_resp     <= 2'b00;
      tx_count_o <= '0;
    end
    else
    begin
      rnd <= 5'($urandom);

      ////////////////////
      // Write side
      if (axil_i.aw_valid && axil_o.aw_ready)
      begin
        aw_got  <= 1'b1;
        wr_addr <= axil_i.aw_addr;
      end
      if (axil_i.w_valid && axil_o.w_ready)
      begin
        w_got   <= 1'b1;
        wr_data <= axil_i.w_data;
        wr_strb <= axil_i.w_strb;
      end
      if (aw_got && w_got && !b_valid && rnd[3])   // Random B delay
      begin
        b_valid <= 1'b1;
        if (in_err_window(wr_addr))
          b_resp <= 2'b10;                         // SLVERR leaves memory untouched
        else
        begin
          b_resp <= 2'b00;
          for (int b = 0; b < 4; b++)
            if (wr_strb[b])
              mem[word_index(wr_addr)][8*b +: 8] <= wr_data[8*b +: 8];
        end
      end
      if (b_valid && axil_i.b_ready)
      begin
        b_valid    <= 1'b0;
        aw_got     <= 1'b0;
        w_got      <= 1'b0;
        tx_count_o <= tx_count_o + 1;
      end

      ////////////////////
      // Read side
      if (axil_i.ar_valid && axil_o.ar_ready)
      begin
        ar_got  <= 1'b1;
        rd_addr <= axil_i.ar_addr;
      end
      if (ar_got && !r_valid && rnd[4])            // Random R delay
      begin
        r_valid <= 1'b1;
        r_data  <= mem[word_index(rd_addr)];
        r_resp  <= in_err_window(rd_addr) ? 2'b10 : 2'b00;
      end
      if (r_valid && axil_i.r_ready)
      begin
        r_valid    <= 1'b0;
        ar_got     <= 1'b0;
        tx_count_o <= tx_count_o + 1;
      end
    end
  end

endmodule

/* dv/dmem_ctrl_tb.sv */
`timescale 1ns/1ps

module dmem_ctrl_tb;

  localparam int PMA_CNT      = 3;
  localparam int MAX_TESTS    = 64;
  localparam int TEST_TIME_NS = 200;   // Watchdog budget per test

  logic                clk_i;
  logic                rst_n_i;
  logic                mem_req_i;
  dmem_pkg::mem_req_t  mem_i;
  logic                mem_ready_o;
  dmem_pkg::data_t     mem_q_o;
  logic                mem_ack_o;
  logic                mem_err_o;
  logic                mem_misaligned_o;
  dmem_pkg::axil_m2s_t axil_m2s;
  dmem_pkg::axil_s2m_t axil_s2m;
  dmem_pkg::pma_cfg_t  pma_cfg [PMA_CNT];
  logic                hold;           // Stalls the slave
  logic [31:0]         tx_count;

  // Test table
  logic [8*24-1:0]  t_name    [MAX_TESTS];
  logic             t_we      [MAX_TESTS];
  dmem_pkg::addr_t  t_addr    [MAX_TESTS];
  dmem_pkg::size_t  t_size    [MAX_TESTS];
  dmem_pkg::data_t  t_wdata   [MAX_TESTS];
  logic [1:0]       t_outcome [MAX_TESTS];  // 0 ack, 1 err, 2 misaligned, 3 none
  dmem_pkg::data_t  t_rdata   [MAX_TESTS];
  logic             t_tx      [MAX_TESTS];
  logic             t_chain   [MAX_TESTS];  // Issue together with the next test
  int               num_tests;
  logic             loaded;
  int               exp_q [$];              // Tests awaiting a response

  dmem_ctrl #(
    .PMA_CNT   ( PMA_CNT ),
    .BUF_DEPTH ( 2       )
  )
  DUT (
    .clk_i            ( clk_i            ),
    .rst_n_i          ( rst_n_i          ),
    .pma_cfg_i        ( pma_cfg          ),
    .mem_req_i        ( mem_req_i        ),
    .mem_i            ( mem_i            ),
    .mem_ready_o      ( mem_ready_o      ),
    .mem_q_o          ( mem_q_o          ),
    .mem_ack_o        ( mem_ack_o        ),
    .mem_err_o        ( mem_err_o        ),
    .mem_misaligned_o ( mem_misaligned_o ),
    .axil_o           ( axil_m2s         ),
    .axil_i           ( axil_s2m         )
  );

  axil_slave_model u_slave (
    .clk_i      ( clk_i    ),
    .rst_n_i    ( rst_n_i  ),
    .hold_i     ( hold     ),
    .axil_i     ( axil_m2s ),
    .axil_o     ( axil_s2m ),
    .tx_count_o ( tx_count )
  );

  // Fixed PMA map
  assign pma_cfg[0] = '{base: 32'h0000_0000, limit: 32'h0000_0FFF, readable: 1'b1, writable: 1'b1};
  assign pma_cfg[1] = '{base: 32'h0000_1000, limit: 32'h0000_1FFF, readable: 1'b1, writable: 1'b0};
  assign pma_cfg[2] = '{base: 32'h0000_2000, limit: 32'h0000_2FFF, readable: 1'b1, writable: 1'b1};

  initial
  begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  ////////////////////
  // Helpers
  task automatic check_value(input logic [8*24-1:0] name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act)
    begin
      $display("Fail %0s: expected %h, actual %h", name, exp, act);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // One-hot {misaligned, err, ack}
  function automatic logic [2:0] outcome_flags(input logic [1:0] outcome);
    case (outcome)
      2'd0:    return 3'b001;
      2'd1:    return 3'b010;
      2'd2:    return 3'b100;
      default: return 3'b000;
    endcase
  endfunction

  task automatic load_tests();
    int              fd;
    int              n;
    string           line;
    logic [8*24-1:0] nm;
    logic [31:0]     op, ad, sz, wd, oc, rd, tx, ch;
    fd = $fopen("dv/dmem_tests.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the tests file dv/dmem_tests.txt");
      $display("STATUS: FAIL");
      $fatal(1, "missing tests file");
    end
    num_tests = 0;
    while (!$feof(fd) && num_tests < MAX_TESTS)
    begin
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 1 && line[0] != "#")
      begin
        n = $sscanf(line, "%s %h %h %h %h %h %h %h %h", nm, op, ad, sz, wd, oc, rd, tx, ch);
        if (n == 9)
        begin
          t_name[num_tests]    = nm;
          t_we[num_tests]      = op[0];
          t_addr[num_tests]    = ad;
          t_size[num_tests]    = sz[1:0];
          t_wdata[num_tests]   = wd;
          t_outcome[num_tests] = oc[1:0];
          t_rdata[num_tests]   = rd;
          t_tx[num_tests]      = tx[0];
          t_chain[num_tests]   = ch[0];
          num_tests++;
        end
      end
    end
    $fclose(fd);
  endtask

  // Entered and left 1 ns after a rising edge
  task automatic send_request(input int idx);
    logic accepted;
    if (t_outcome[idx] != 2'd3)
      exp_q.push_back(idx);
    mem_req_i  = 1'b1;
    mem_i.addr = t_addr[idx];
    mem_i.size = t_size[idx];
    mem_i.we   = t_we[idx];
    mem_i.data = t_wdata[idx];
    accepted   = 1'b0;
    while (!accepted)
    begin
      @(negedge clk_i);
      accepted = mem_ready_o;  // Stable until the next edge
      @(posedge clk_i);
      #1;
    end
    mem_req_i = 1'b0;
  endtask

  ////////////////////
  // Response monitor in request order
  always @(negedge clk_i)
  begin : resp_monitor
    int idx;
    if (rst_n_i && (mem_ack_o || mem_err_o || mem_misaligned_o))
    begin
      if (exp_q.size() == 0)
      begin
        $display("A response arrived while no request was waiting for one");
        $display("STATUS: FAIL");
        $fatal(1, "unexpected response");
      end
      idx = exp_q.pop_front();
      check_value(t_name[idx], 32'(outcome_flags(t_outcome[idx])),
                  32'({mem_misaligned_o, mem_err_o, mem_ack_o}));
      if (mem_ack_o && !t_we[idx])
        check_value(t_name[idx], t_rdata[idx], mem_q_o);
    end
  end

  // Unprivileged secure data access on every address phase
  always @(negedge clk_i)
  begin
    if (rst_n_i && axil_m2s.aw_valid)
      check_value("aw_prot", 32'h0, 32'(axil_m2s.aw_prot));
    if (rst_n_i && axil_m2s.ar_valid)
      check_value("ar_prot", 32'h0, 32'(axil_m2s.ar_prot));
  end

  // Watchdog
  initial
  begin
    wait (loaded);
    #(num_tests * TEST_TIME_NS * 1ns);
    $display("Timeout: the tests did not finish in the allowed time");
    $display("STATUS: FAIL");
    $fatal(1, "timeout");
  end

  ////////////////////
  // Main sequence
  initial
  begin
    int          i;
    int          last;
    int          exp_tx;
    logic [31:0] tx_before;
    void'($urandom(26));
    rst_n_i   = 1'b0;
    mem_req_i = 1'b0;
    mem_i     = '0;
    hold      = 1'b0;
    loaded    = 1'b0;
    load_tests();
    loaded = 1'b1;
    repeat (2) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    @(negedge clk_i);
    check_value("reset", 32'h1, 32'(mem_ready_o));
    check_value("reset", 32'h0, 32'({mem_ack_o, mem_err_o, mem_misaligned_o}));
    check_value("reset", 32'h0, 32'({axil_m2s.aw_valid, axil_m2s.w_valid, axil_m2s.b_ready,
                                     axil_m2s.ar_valid, axil_m2s.r_ready}));
    @(posedge clk_i);
    #1;

    i = 0;
    while (i < num_tests)
    begin
      tx_before = tx_count;
      if (t_chain[i] && i + 1 < num_tests)
      begin
        hold = 1'b1;                          // Keep the first one on the bus
        send_request(i);
        send_request(i + 1);
        @(negedge clk_i);
        check_value(t_name[i + 1], 32'h0, 32'(mem_ready_o));  // Buffer full
        @(posedge clk_i);
        #1;
        hold = 1'b0;
        last = i + 1;
      end
      else
      begin
        send_request(i);
        last = i;
        if (!t_tx[i] && t_outcome[i] != 2'd3)
        begin
          // Failed check answers one cycle after the head appears
          @(negedge clk_i);
          @(negedge clk_i);
          check_value(t_name[i], 32'(outcome_flags(t_outcome[i])),
                      32'({mem_misaligned_o, mem_err_o, mem_ack_o}));
        end
      end
      while (exp_q.size() != 0)
        @(posedge clk_i);
      repeat (5) @(posedge clk_i);           // Room for any stray activity
      #1;
      exp_tx = 0;
      for (int k = i; k <= last; k++)
        exp_tx += int'(t_tx[k]);
      check_value(t_name[last], 32'(exp_tx), tx_count - tx_before);
      i = last + 1;
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* dv/dmem_tests.txt */
# name op(1=wr) addr size(0=b,1=h,2=w) wdata outcome(0=ack,1=err,2=mis,3=none)
# rdata bus_tx chain(1=issue with next line); all numbers hex
wr_word        1 00000100 2 11223344 0 00000000 1 0
rd_word        0 00000100 2 00000000 0 11223344 1 0
wr_half        1 00000102 1 AABB0000 0 00000000 1 0
rd_after_half  0 00000100 2 00000000 0 AABB3344 1 0
wr_byte        1 00000101 0 0000CC00 0 00000000 1 0
rd_after_byte  0 00000100 2 00000000 0 AABBCC44 1 0
mis_half_wr    1 00000103 1 00000000 2 00000000 0 0
mis_word_rd    0 00000102 2 00000000 2 00000000 0 0
wr_readonly    1 00001000 2 DEADBEEF 1 00000000 0 0
rd_readonly    0 00001000 2 00000000 0 A5A51000 1 0
rd_unmapped    0 00003000 2 00000000 1 00000000 0 0
wr_unmapped    1 00004000 2 00000000 1 00000000 0 0
wr_slverr      1 00002800 2 01020304 1 00000000 1 0
rd_slverr      0 00002FFC 2 00000000 1 00000000 1 0
b2b_wr         1 00002000 2 CAFE0001 0 00000000 1 1
b2b_rd         0 00002000 2 00000000 0 CAFE0001 1 0
fail_first     1 00001004 2 00000000 1 00000000 0 1
dropped_wr     1 00000200 2 12345678 3 00000000 0 0
rd_not_written 0 00000200 2 00000000 0 A5A50200 1 0

/* filelist.f */
logic/dmem_pkg.sv
logic/dmem_reqbuf.sv
logic/dmem_pmachk.sv
logic/dmem_axil_master.sv
logic/dmem_ctrl.sv
dv/axil_slave_model.sv
dv/dmem_ctrl_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = dmem_ctrl_tb
RTL_TOP  = dmem_ctrl
FILELIST = filelist.f
OBJ_DIR  = obj_dir

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf $(OBJ_DIR)
